//--- src/intra_pkg.sv
`default_nettype none

package intra_pkg;

    typedef logic [7:0]         pix_t;
    typedef logic [10:0]        nbr_t;
    typedef logic signed [8:0]  res_t;
    typedef logic signed [14:0] coef_t;
    typedef logic [5:0]         qp_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRED,
        ST_RES,
        ST_DCTQ,
        ST_IDCT,
        ST_RECON
    } pe_state_e;

    // Rows by qp % 6, columns by class: even/even, odd/odd, mixed
    localparam int QUANT_MF [0:5][0:2] = '{
        '{13107, 5243, 8066},
        '{11916, 4660, 7490},
        '{10082, 4194, 6554},
        '{ 9362, 3647, 5825},
        '{ 8192, 3355, 5243},
        '{ 7282, 2893, 4559}
    };

    localparam int DEQUANT_V [0:5][0:2] = '{
        '{10, 16, 13},
        '{11, 18, 14},
        '{13, 20, 16},
        '{14, 23, 18},
        '{16, 25, 20},
        '{18, 29, 23}
    };

    localparam int   QBITS_BASE      = 15;
    localparam int   INTRA_ROUND_DIV = 3;
    localparam pix_t DC_DEFAULT      = 8'd128;

    // Scaling class of a coefficient position
    function automatic int pos_class(input int row, input int col);
        if ((row % 2 == 0) && (col % 2 == 0)) return 0;
        if ((row % 2 == 1) && (col % 2 == 1)) return 1;
        return 2;
    endfunction

endpackage

`default_nettype wire

//--- src/intra_dc_pred.sv
`timescale 1ns/1ps
`default_nettype none

module intra_dc_pred (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            clear_i,
    input  wire logic            start_i,
    input  wire logic            pred_en_i,
    input  wire intra_pkg::nbr_t top_i [0:3],
    input  wire intra_pkg::nbr_t left_i [0:3],
    input  wire logic            top_valid_i,
    input  wire logic            left_valid_i,
    output intra_pkg::pix_t      pred_o
);

    intra_pkg::nbr_t top_q [0:3];
    intra_pkg::nbr_t left_q [0:3];
    logic            top_v_q;
    logic            left_v_q;
    logic [12:0]     top_sum;
    logic [12:0]     left_sum;
    logic [13:0]     all_sum;
    intra_pkg::pix_t dc_d;

    // Neighbours are held for the whole block
    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            top_q    <= '{default: '0};
            left_q   <= '{default: '0};
            top_v_q  <= 1'b0;
            left_v_q <= 1'b0;
        end else if (start_i) begin
            top_q    <= top_i;
            left_q   <= left_i;
            top_v_q  <= top_valid_i;
            left_v_q <= left_valid_i;
        end
    end

    always_comb begin
        top_sum  = 13'(top_q[0]) + 13'(top_q[1]) + 13'(top_q[2]) + 13'(top_q[3]);
        left_sum = 13'(left_q[0]) + 13'(left_q[1]) + 13'(left_q[2]) + 13'(left_q[3]);
        all_sum  = {1'b0, top_sum} + {1'b0, left_sum};
    end

    always_comb begin
        case ({top_v_q, left_v_q})
            2'b00:   dc_d = intra_pkg::DC_DEFAULT;
            2'b10:   dc_d = intra_pkg::pix_t'((top_sum + 13'd2) >> 2);
            2'b01:   dc_d = intra_pkg::pix_t'((left_sum + 13'd2) >> 2);
            default: dc_d = intra_pkg::pix_t'((all_sum + 14'd4) >> 3);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            pred_o <= '0;
        end else if (pred_en_i) begin
            pred_o <= dc_d;
        end
    end

endmodule

`default_nettype wire

//--- src/tq_dct_quant.sv
`timescale 1ns/1ps
`default_nettype none

module tq_dct_quant (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            clear_i,
    input  wire logic            en_i,
    input  wire intra_pkg::qp_t  qp_i,
    input  wire intra_pkg::res_t res_i [0:3][0:3],
    output intra_pkg::coef_t     coef_o [0:3][0:3]
);

    int               qp_div;
    int               qp_mod;
    int               qbits;
    int               rnd_off;
    int               row_v [0:3][0:3];
    int               col_v [0:3][0:3];
    intra_pkg::coef_t coef_d [0:3][0:3];

    always_comb begin
        qp_div  = int'(qp_i) / 6;
        qp_mod  = int'(qp_i) % 6;
        qbits   = intra_pkg::QBITS_BASE + qp_div;
        // Intra dead zone of one third
        rnd_off = (1 << qbits) / intra_pkg::INTRA_ROUND_DIV;
    end

    // Horizontal pass
    always_comb begin : row_pass
        int s03;
        int s12;
        int d03;
        int d12;
        for (int i = 0; i < 4; i++) begin
            s03 = int'(res_i[i][0]) + int'(res_i[i][3]);
            s12 = int'(res_i[i][1]) + int'(res_i[i][2]);
            d03 = int'(res_i[i][0]) - int'(res_i[i][3]);
            d12 = int'(res_i[i][1]) - int'(res_i[i][2]);
            row_v[i][0] = s03 + s12;
            row_v[i][1] = 2 * d03 + d12;
            row_v[i][2] = s03 - s12;
            row_v[i][3] = d03 - 2 * d12;
        end
    end

    // Vertical pass
    always_comb begin : col_pass
        int s03;
        int s12;
        int d03;
        int d12;
        for (int k = 0; k < 4; k++) begin
            s03 = row_v[0][k] + row_v[3][k];
            s12 = row_v[1][k] + row_v[2][k];
            d03 = row_v[0][k] - row_v[3][k];
            d12 = row_v[1][k] - row_v[2][k];
            col_v[0][k] = s03 + s12;
            col_v[1][k] = 2 * d03 + d12;
            col_v[2][k] = s03 - s12;
            col_v[3][k] = d03 - 2 * d12;
        end
    end

    // Quantise on the magnitude, sign restored afterwards
    always_comb begin : quant
        int   mag;
        int   mf;
        int   q;
        logic neg;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                neg = (col_v[i][j] < 0);
                mag = neg ? -col_v[i][j] : col_v[i][j];
                mf  = intra_pkg::QUANT_MF[qp_mod][intra_pkg::pos_class(i, j)];
                q   = (mag * mf + rnd_off) >>> qbits;
                coef_d[i][j] = intra_pkg::coef_t'(neg ? -q : q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    coef_o[i][j] <= '0;
                end
            end
        end else if (en_i) begin
            coef_o <= coef_d;
        end
    end

endmodule

`default_nettype wire

//--- src/tq_idct_dequant.sv
`timescale 1ns/1ps
`default_nettype none

module tq_idct_dequant (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             clear_i,
    input  wire logic             en_i,
    input  wire intra_pkg::qp_t   qp_i,
    input  wire intra_pkg::coef_t coef_i [0:3][0:3],
    output logic signed [15:0]    resid_o [0:3][0:3]
);

    int                 qp_div;
    int                 qp_mod;
    int                 dq_v  [0:3][0:3];
    int                 row_v [0:3][0:3];
    int                 col_v [0:3][0:3];
    logic signed [15:0] resid_d [0:3][0:3];

    always_comb begin
        qp_div = int'(qp_i) / 6;
        qp_mod = int'(qp_i) % 6;
    end

    // Level scale, flat weighting
    always_comb begin : dequant
        int v;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                v = intra_pkg::DEQUANT_V[qp_mod][intra_pkg::pos_class(i, j)];
                dq_v[i][j] = (int'(coef_i[i][j]) * v) <<< qp_div;
            end
        end
    end

    // Horizontal pass, odd inputs at half weight
    always_comb begin : row_pass
        int e0;
        int e1;
        int e2;
        int e3;
        for (int i = 0; i < 4; i++) begin
            e0 = dq_v[i][0] + dq_v[i][2];
            e1 = dq_v[i][0] - dq_v[i][2];
            e2 = (dq_v[i][1] >>> 1) - dq_v[i][3];
            e3 = dq_v[i][1] + (dq_v[i][3] >>> 1);
            row_v[i][0] = e0 + e3;
            row_v[i][1] = e1 + e2;
            row_v[i][2] = e1 - e2;
            row_v[i][3] = e0 - e3;
        end
    end

    // Vertical pass
    always_comb begin : col_pass
        int e0;
        int e1;
        int e2;
        int e3;
        for (int k = 0; k < 4; k++) begin
            e0 = row_v[0][k] + row_v[2][k];
            e1 = row_v[0][k] - row_v[2][k];
            e2 = (row_v[1][k] >>> 1) - row_v[3][k];
            e3 = row_v[1][k] + (row_v[3][k] >>> 1);
            col_v[0][k] = e0 + e3;
            col_v[1][k] = e1 + e2;
            col_v[2][k] = e1 - e2;
            col_v[3][k] = e0 - e3;
        end
    end

    // Final scaling by 1/64 with rounding
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                resid_d[i][j] = 16'((col_v[i][j] + 32) >>> 6);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    resid_o[i][j] <= '0;
                end
            end
        end else if (en_i) begin
            resid_o <= resid_d;
        end
    end

endmodule

`default_nettype wire

//--- src/intra_4x4_pe.sv
`timescale 1ns/1ps
`default_nettype none

module intra_4x4_pe (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            clear_i,
    input  wire logic            start_i,
    input  wire intra_pkg::qp_t  qp_i,
    input  wire intra_pkg::nbr_t top_i [0:3],
    input  wire intra_pkg::nbr_t left_i [0:3],
    input  wire logic            top_valid_i,
    input  wire logic            left_valid_i,
    input  wire intra_pkg::pix_t block_i [0:3][0:3],
    output logic                 busy_o,
    output logic                 done_o,
    output intra_pkg::coef_t     coef_o [0:3][0:3],
    output intra_pkg::pix_t      recon_o [0:3][0:3]
);

    intra_pkg::pe_state_e state_q;
    intra_pkg::pe_state_e state_d;
    logic                 start_ok;
    logic                 done_q;
    logic                 pred_en;
    logic                 dctq_en;
    logic                 idct_en;
    intra_pkg::qp_t       qp_q;
    intra_pkg::pix_t      block_q [0:3][0:3];
    intra_pkg::res_t      res_q   [0:3][0:3];
    intra_pkg::pix_t      pred;
    logic signed [15:0]   resid   [0:3][0:3];
    intra_pkg::pix_t      recon_d [0:3][0:3];

    // Busy also covers the done cycle so a start there is dropped
    assign busy_o   = (state_q != intra_pkg::ST_IDLE) || done_q;
    assign done_o   = done_q;
    assign start_ok = start_i && !busy_o;

    assign pred_en = (state_q == intra_pkg::ST_PRED);
    assign dctq_en = (state_q == intra_pkg::ST_DCTQ);
    assign idct_en = (state_q == intra_pkg::ST_IDCT);

    always_comb begin
        case (state_q)
            intra_pkg::ST_IDLE:  state_d = start_ok ? intra_pkg::ST_PRED : intra_pkg::ST_IDLE;
            intra_pkg::ST_PRED:  state_d = intra_pkg::ST_RES;
            intra_pkg::ST_RES:   state_d = intra_pkg::ST_DCTQ;
            intra_pkg::ST_DCTQ:  state_d = intra_pkg::ST_IDCT;
            intra_pkg::ST_IDCT:  state_d = intra_pkg::ST_RECON;
            default:             state_d = intra_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            state_q <= intra_pkg::ST_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == intra_pkg::ST_RECON);
        end
    end

    // Source block and qp are held for the whole block
    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            qp_q    <= '0;
            block_q <= '{default: '0};
        end else if (start_ok) begin
            qp_q    <= qp_i;
            block_q <= block_i;
        end
    end

    intra_dc_pred u_pred (
        .clk          (clk),
        .rst          (rst),
        .clear_i      (clear_i),
        .start_i      (start_ok),
        .pred_en_i    (pred_en),
        .top_i        (top_i),
        .left_i       (left_i),
        .top_valid_i  (top_valid_i),
        .left_valid_i (left_valid_i),
        .pred_o       (pred)
    );

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            res_q <= '{default: '0};
        end else if (state_q == intra_pkg::ST_RES) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    res_q[i][j] <= $signed({1'b0, block_q[i][j]}) - $signed({1'b0, pred});
                end
            end
        end
    end

    tq_dct_quant u_dctq (
        .clk     (clk),
        .rst     (rst),
        .clear_i (clear_i),
        .en_i    (dctq_en),
        .qp_i    (qp_q),
        .res_i   (res_q),
        .coef_o  (coef_o)
    );

    tq_idct_dequant u_idct (
        .clk     (clk),
        .rst     (rst),
        .clear_i (clear_i),
        .en_i    (idct_en),
        .qp_i    (qp_q),
        .coef_i  (coef_o),
        .resid_o (resid)
    );

    // Prediction plus decoded residual, saturated to 8 bits
    always_comb begin : recon_clip
        int sum;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                sum = int'(pred) + int'(resid[i][j]);
                if (sum < 0) begin
                    recon_d[i][j] = 8'd0;
                end else if (sum > 255) begin
                    recon_d[i][j] = 8'd255;
                end else begin
                    recon_d[i][j] = intra_pkg::pix_t'(sum);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            recon_o <= '{default: '0};
        end else if (state_q == intra_pkg::ST_RECON) begin
            recon_o <= recon_d;
        end
    end

endmodule

`default_nettype wire

//--- dv/intra_4x4_pe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module intra_4x4_pe_tb;

    localparam int HALF_PERIOD = 5;
    localparam int CLK_PERIOD  = 2 * HALF_PERIOD;
    localparam int RST_CYCLES  = 3;
    localparam int N_ROWS      = 16;
    localparam int N_FIXED     = 8;
    localparam int LATENCY     = 6;
    localparam int WAIT_MAX    = 20;
    localparam int WATCHDOG_NS = (N_ROWS * LATENCY + 50 + RST_CYCLES) * CLK_PERIOD;
    localparam int SEED        = 32'h2a87_29ab;

    // Core transform matrix, applied as C * X * C^T
    localparam int FWD [0:3][0:3] = '{'{1, 1, 1, 1}, '{2, 1, -1, -2},
                                      '{1, -1, -1, 1}, '{1, -2, 2, -1}};

    logic                 clk;
    logic                 rst;
    logic                 clear;
    logic                 start;
    intra_pkg::qp_t       qp;
    intra_pkg::nbr_t      top   [0:3];
    intra_pkg::nbr_t      left  [0:3];
    logic                 top_valid;
    logic                 left_valid;
    intra_pkg::pix_t      block [0:3][0:3];
    logic                 busy;
    logic                 done;
    intra_pkg::coef_t     coef  [0:3][0:3];
    intra_pkg::pix_t      recon [0:3][0:3];

    // Stimulus table
    intra_pkg::pix_t      tbl_blk  [0:N_ROWS-1][0:3][0:3];
    intra_pkg::pix_t      tbl_top  [0:N_ROWS-1][0:3];
    intra_pkg::pix_t      tbl_left [0:N_ROWS-1][0:3];
    logic                 tbl_tv   [0:N_ROWS-1];
    logic                 tbl_lv   [0:N_ROWS-1];
    intra_pkg::qp_t       tbl_qp   [0:N_ROWS-1];
    logic                 tbl_flat [0:N_ROWS-1];
    logic                 tbl_dup  [0:N_ROWS-1];

    int                   exp_dc;
    int                   exp_coef  [0:3][0:3];
    int                   exp_recon [0:3][0:3];
    int                   err_sum   [0:N_ROWS-1];
    int                   errors;
    int                   n_checks;

    intra_4x4_pe dut0 (
        .clk          (clk),
        .rst          (rst),
        .clear_i      (clear),
        .start_i      (start),
        .qp_i         (qp),
        .top_i        (top),
        .left_i       (left),
        .top_valid_i  (top_valid),
        .left_valid_i (left_valid),
        .block_i      (block),
        .busy_o       (busy),
        .done_o       (done),
        .coef_o       (coef),
        .recon_o      (recon)
    );

    always #(HALF_PERIOD) clk = ~clk;

    function automatic int scale_class(input int row, input int col);
        if ((row % 2) != (col % 2)) begin
            return 2;
        end
        return row % 2;
    endfunction

    // One output of the 1-D inverse transform, odd inputs at half weight
    function automatic int inv_tap(input int a0, input int a1, input int a2, input int a3,
                                   input int n);
        int even;
        int odd;
        even = (n == 0 || n == 3) ? a0 + a2 : a0 - a2;
        odd  = (n == 0 || n == 3) ? a1 + (a3 >>> 1) : (a1 >>> 1) - a3;
        return (n < 2) ? even + odd : even - odd;
    endfunction

    task automatic model_block(input int r);
        int x [0:3][0:3];
        int t [0:3][0:3];
        int y [0:3][0:3];
        int ts;
        int ls;
        int qd;
        int qm;
        int qb;
        int mag;
        int q;
        int s;
        ts = 0;
        ls = 0;
        for (int k = 0; k < 4; k++) begin
            ts = ts + int'(tbl_top[r][k]);
            ls = ls + int'(tbl_left[r][k]);
        end
        if (tbl_tv[r] && tbl_lv[r]) exp_dc = (ts + ls + 4) >> 3;
        else if (tbl_tv[r]) exp_dc = (ts + 2) >> 2;
        else if (tbl_lv[r]) exp_dc = (ls + 2) >> 2;
        else exp_dc = int'(intra_pkg::DC_DEFAULT);
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                x[i][j] = int'(tbl_blk[r][i][j]) - exp_dc;
            end
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                t[i][j] = 0;
                for (int k = 0; k < 4; k++) t[i][j] = t[i][j] + FWD[i][k] * x[k][j];
            end
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                y[i][j] = 0;
                for (int k = 0; k < 4; k++) y[i][j] = y[i][j] + t[i][k] * FWD[j][k];
            end
        end
        qd = int'(tbl_qp[r]) / 6;
        qm = int'(tbl_qp[r]) % 6;
        qb = intra_pkg::QBITS_BASE + qd;
        // Quantise, then rescale into x for the decoder side
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                mag = (y[i][j] < 0) ? -y[i][j] : y[i][j];
                q   = (mag * intra_pkg::QUANT_MF[qm][scale_class(i, j)]
                       + (1 << qb) / intra_pkg::INTRA_ROUND_DIV) >> qb;
                exp_coef[i][j] = (y[i][j] < 0) ? -q : q;
                x[i][j] = exp_coef[i][j] * intra_pkg::DEQUANT_V[qm][scale_class(i, j)]
                          * (1 << qd);
            end
        end
        for (int i = 0; i < 4; i++) begin
            for (int n = 0; n < 4; n++) t[i][n] = inv_tap(x[i][0], x[i][1], x[i][2], x[i][3], n);
        end
        for (int k = 0; k < 4; k++) begin
            for (int n = 0; n < 4; n++) y[n][k] = inv_tap(t[0][k], t[1][k], t[2][k], t[3][k], n);
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                s = exp_dc + ((y[i][j] + 32) >>> 6);
                exp_recon[i][j] = (s < 0) ? 0 : ((s > 255) ? 255 : s);
            end
        end
    endtask

    task automatic set_nbrs(input int r, input int t_base, input int t_step, input int l_base,
                            input int l_step, input logic tv, input logic lv, input int qp_val);
        for (int k = 0; k < 4; k++) begin
            tbl_top[r][k]  = 8'(t_base + k * t_step);
            tbl_left[r][k] = 8'(l_base + k * l_step);
        end
        tbl_tv[r] = tv;
        tbl_lv[r] = lv;
        tbl_qp[r] = 6'(qp_val);
    endtask

    task automatic fill_flat(input int r, input int v);
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) tbl_blk[r][i][j] = 8'(v);
        end
        tbl_flat[r] = 1'b1;
    endtask

    task automatic fill_table();
        for (int r = 0; r < N_ROWS; r++) begin
            tbl_flat[r] = 1'b0;
            tbl_dup[r]  = 1'b0;
            err_sum[r]  = 0;
        end
        // Flat blocks at the DC value, one per availability case
        set_nbrs(0, 0, 0, 0, 0, 1'b0, 1'b0, 28);
        fill_flat(0, 128);
        set_nbrs(1, 10, 10, 0, 0, 1'b1, 1'b0, 20);
        fill_flat(1, 25);
        set_nbrs(2, 0, 0, 200, 1, 1'b0, 1'b1, 30);
        fill_flat(2, 202);
        set_nbrs(3, 50, 10, 90, 10, 1'b1, 1'b1, 12);
        fill_flat(3, 85);
        // Checkerboard of 0 and 255, then a ramp, each at qp 0 and 51
        for (int r = 4; r < N_FIXED; r++) begin
            if (r < 6) set_nbrs(r, 128, 0, 128, 0, 1'b1, 1'b1, (r == 4) ? 0 : 51);
            else set_nbrs(r, 0, 0, 0, 0, 1'b0, 1'b0, (r == 6) ? 0 : 51);
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    tbl_blk[r][i][j] = (r < 6) ? (((i + j) % 2 == 1) ? 8'd255 : 8'd0)
                                               : 8'(16 * (4 * i + j));
                end
            end
        end
        tbl_dup[6] = 1'b1;
        for (int r = N_FIXED; r < N_ROWS; r++) begin
            for (int k = 0; k < 4; k++) begin
                tbl_top[r][k]  = 8'($urandom);
                tbl_left[r][k] = 8'($urandom);
            end
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) tbl_blk[r][i][j] = 8'($urandom);
            end
            tbl_tv[r] = 1'($urandom);
            tbl_lv[r] = 1'($urandom);
            tbl_qp[r] = 6'($urandom % 52);
        end
    endtask

    task automatic drive_row(input int r);
        for (int k = 0; k < 4; k++) begin
            top[k]  = intra_pkg::nbr_t'(tbl_top[r][k]);
            left[k] = intra_pkg::nbr_t'(tbl_left[r][k]);
        end
        block      = tbl_blk[r];
        top_valid  = tbl_tv[r];
        left_valid = tbl_lv[r];
        qp         = tbl_qp[r];
    endtask

    task automatic check_outputs(input int r);
        int d;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                n_checks += 2;
                assert (int'(coef[i][j]) == exp_coef[i][j]) else begin
                    $display("FAIL %0t: row %0d coef[%0d][%0d] got %0d expected %0d",
                             $time, r, i, j, coef[i][j], exp_coef[i][j]);
                    errors++;
                end
                assert (int'(recon[i][j]) == exp_recon[i][j]) else begin
                    $display("FAIL %0t: row %0d recon[%0d][%0d] got %0d expected %0d",
                             $time, r, i, j, recon[i][j], exp_recon[i][j]);
                    errors++;
                end
                if (tbl_flat[r]) begin
                    n_checks++;
                    assert (coef[i][j] == '0 && recon[i][j] == tbl_blk[r][i][j]) else begin
                        $display("FAIL %0t: row %0d flat block not predicted exactly at [%0d][%0d]",
                                 $time, r, i, j);
                        errors++;
                    end
                end
                d = int'(recon[i][j]) - int'(tbl_blk[r][i][j]);
                err_sum[r] = err_sum[r] + ((d < 0) ? -d : d);
            end
        end
    endtask

    task automatic run_block(input int r);
        int cycles;
        model_block(r);
        drive_row(r);
        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 1;
        n_checks++;
        assert (busy === 1'b1) else begin
            $display("FAIL %0t: row %0d busy_o low after start", $time, r);
            errors++;
        end
        while (done !== 1'b1 && cycles < WAIT_MAX) begin
            @(negedge clk);
            cycles++;
            if (tbl_dup[r] && cycles == 2) begin
                // A second start with other data while busy must be dropped
                for (int i = 0; i < 4; i++) begin
                    for (int j = 0; j < 4; j++) block[i][j] = ~tbl_blk[r][i][j];
                end
                qp         = '0;
                top_valid  = ~tbl_tv[r];
                left_valid = ~tbl_lv[r];
                start      = 1'b1;
            end else begin
                start = 1'b0;
            end
        end
        n_checks++;
        assert (done === 1'b1) else begin
            $display("Row %0d: done_o did not go high within %0d cycles of start", r, WAIT_MAX);
            errors++;
        end
        if (done === 1'b1) begin
            n_checks++;
            assert (cycles == LATENCY) else begin
                $display("FAIL %0t: row %0d latency got %0d expected %0d",
                         $time, r, cycles, LATENCY);
                errors++;
            end
            check_outputs(r);
        end
        @(negedge clk);
        n_checks++;
        assert (done === 1'b0 && busy === 1'b0) else begin
            $display("FAIL %0t: row %0d done_o or busy_o high after the done cycle", $time, r);
            errors++;
        end
    endtask

    task automatic check_idle_zero(input string what);
        n_checks++;
        assert (busy === 1'b0 && done === 1'b0) else begin
            $display("FAIL %0t: busy_o or done_o high after %s", $time, what);
            errors++;
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                n_checks++;
                assert (coef[i][j] == '0 && recon[i][j] == '0) else begin
                    $display("FAIL %0t: output [%0d][%0d] not zero after %s", $time, i, j, what);
                    errors++;
                end
            end
        end
    endtask

    task automatic clear_in_flight();
        drive_row(N_ROWS - 1);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (2) @(negedge clk);
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        check_idle_zero("clear");
        repeat (8) begin
            @(negedge clk);
            n_checks++;
            assert (done === 1'b0) else begin
                $display("A done_o pulse came from a block that was cleared");
                errors++;
            end
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        errors     = 0;
        n_checks   = 0;
        clk        = 1'b0;
        rst        = 1'b1;
        clear      = 1'b0;
        start      = 1'b0;
        qp         = '0;
        top        = '{default: '0};
        left       = '{default: '0};
        top_valid  = 1'b0;
        left_valid = 1'b0;
        block      = '{default: '0};
        void'($urandom(SEED));
        fill_table();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_idle_zero("reset");
        for (int r = 0; r < N_ROWS; r++) run_block(r);
        // Coarser quantiser must lose more of the source block
        n_checks += 2;
        assert (err_sum[5] > err_sum[4]) else begin
            $display("FAIL %0t: checkerboard error at qp 51 (%0d) not above qp 0 (%0d)",
                     $time, err_sum[5], err_sum[4]);
            errors++;
        end
        assert (err_sum[7] > err_sum[6]) else begin
            $display("FAIL %0t: ramp error at qp 51 (%0d) not above qp 0 (%0d)",
                     $time, err_sum[7], err_sum[6]);
            errors++;
        end
        clear_in_flight();
        $display("Checks: %0d, errors: %0d", n_checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- intra_4x4_pe.f
src/intra_pkg.sv
src/intra_dc_pred.sv
src/tq_dct_quant.sv
src/tq_idct_dequant.sv
src/intra_4x4_pe.sv
dv/intra_4x4_pe_tb.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= intra_4x4_pe_tb
FILELIST  ?= intra_4x4_pe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
